/* hw/lpif_adapter.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_adapter
  import lpif_pkg::*;
(
  input  wire logic                      lclk,
  input  wire logic                      reset,

  // Upper layer
  input  wire logic                      lp_irdy,
  input  wire logic                      lp_valid,
  input  wire logic [LPIF_DATA_BITS-1:0] lp_data,
  input  wire logic [STREAM_BITS-1:0]    lp_stream,
  input  lsm_state_e                     lp_state_req,
  input  wire logic                      lp_linkerror,
  output logic                           pl_trdy,
  output logic                           pl_valid,
  output logic [LPIF_DATA_BITS-1:0]      pl_data,
  output logic [STREAM_BITS-1:0]         pl_stream,
  output lsm_state_e                     pl_state_sts,
  output logic                           pl_lnk_up,

  // AIB side
  input  wire logic                      fs_mac_rdy,
  output logic                           ns_mac_rdy,
  input  wire logic                      lpbk_en,
  input  aib_frame_t                     dout,
  output aib_frame_t                     data_in_f
);

  lpif_beat_t lp_beat;      // Registered upper-layer beat
  lsm_state_e lp_state;     // Registered state request
  logic       lp_err;
  lsm_state_e sts;          // Current LSM state
  logic       link_active;
  aib_frame_t rx_frame;     // Far side or loopback frame
  lpif_beat_t rx_beat;      // Received beat before output stage

  //////////////////////////////////////////////////////////////////////
  // Upper-layer register stages
  //////////////////////////////////////////////////////////////////////

  lpif_pipeline u_pipeline (
    .lclk         (lclk),
    .reset        (reset),
    .lp_irdy      (lp_irdy),
    .lp_valid     (lp_valid),
    .lp_data      (lp_data),
    .lp_stream    (lp_stream),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .link_active  (link_active),
    .sts          (sts),
    .rx_beat      (rx_beat),
    .lp_beat      (lp_beat),
    .lp_state     (lp_state),
    .lp_err       (lp_err),
    .pl_trdy      (pl_trdy),
    .pl_valid     (pl_valid),
    .pl_data      (pl_data),
    .pl_stream    (pl_stream),
    .pl_state_sts (pl_state_sts),
    .pl_lnk_up    (pl_lnk_up)
  );

  lpif_lsm u_lsm (
    .lclk        (lclk),
    .reset       (reset),
    .lp_state    (lp_state),
    .lp_err      (lp_err),
    .fs_mac_rdy  (fs_mac_rdy),
    .sts         (sts),
    .link_active (link_active),
    .ns_mac_rdy  (ns_mac_rdy)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  lpif_tx_framer u_tx_framer (
    .lclk      (lclk),
    .reset     (reset),
    .lp_beat   (lp_beat),
    .data_in_f (data_in_f)
  );

  lpif_lpbk u_lpbk (
    .lclk      (lclk),
    .reset     (reset),
    .lpbk_en   (lpbk_en),
    .data_in_f (data_in_f),
    .dout      (dout),
    .rx_frame  (rx_frame)
  );

  lpif_rx_deframer u_rx_deframer (
    .lclk        (lclk),
    .reset       (reset),
    .rx_frame    (rx_frame),
    .link_active (link_active),
    .rx_beat     (rx_beat)
  );

endmodule

`default_nettype wire

/* hw/lpif_lpbk.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_lpbk
  import lpif_pkg::*;
(
  input  wire logic lclk,
  input  wire logic reset,
  input  wire logic lpbk_en,
  input  aib_frame_t data_in_f,    // Own transmit frame
  input  aib_frame_t dout,         // Frame from the far side
  output aib_frame_t rx_frame
);

  //////////////////////////////////////////////////////////////////////
  // Receive source select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
      rx_frame <= '0;                 // Idle frame
    else if (lpbk_en)
      rx_frame <= data_in_f;          // Near-side loopback
    else
      rx_frame <= dout;
  end

endmodule

`default_nettype wire

/* hw/lpif_lsm.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_lsm
  import lpif_pkg::*;
(
  input  wire logic lclk,
  input  wire logic reset,
  input  lsm_state_e lp_state,     // Requested state, already registered
  input  wire logic lp_err,
  input  wire logic fs_mac_rdy,
  output lsm_state_e sts,
  output logic      link_active,
  output logic      ns_mac_rdy
);

  lsm_state_e state;
  lsm_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      NOP,
      LINKRESET:
      begin
        if ((lp_state == ACTIVE) && fs_mac_rdy)   // Far side must be up too
          state_nxt = ACTIVE;
      end
      ACTIVE:
      begin
        if (lp_state == LINKRESET)
          state_nxt = LINKRESET;
      end
      LINKERROR:
      begin
        if ((lp_state == LINKRESET) && !lp_err)
          state_nxt = LINKRESET;
      end
      default:
        state_nxt = NOP;
    endcase

    // Error from the upper layer wins over any request
    if (lp_err)
      state_nxt = LINKERROR;
  end

  //////////////////////////////////////////////////////////////////////
  // State and ready flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
      state <= NOP;
    else
      state <= state_nxt;
  end

  // Near side ready from the first edge out of reset
  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
      ns_mac_rdy <= 1'b0;
    else
      ns_mac_rdy <= 1'b1;
  end

  assign sts         = state;
  assign link_active = (state == ACTIVE);

endmodule

`default_nettype wire

/* hw/lpif_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_pipeline
  import lpif_pkg::*;
(
  input  wire logic                      lclk,
  input  wire logic                      reset,

  // Upper layer in
  input  wire logic                      lp_irdy,
  input  wire logic                      lp_valid,
  input  wire logic [LPIF_DATA_BITS-1:0] lp_data,
  input  wire logic [STREAM_BITS-1:0]    lp_stream,
  input  lsm_state_e                     lp_state_req,
  input  wire logic                      lp_linkerror,

  // Core side in
  input  wire logic                      link_active,
  input  lsm_state_e                     sts,
  input  lpif_beat_t                     rx_beat,

  // Core side out
  output lpif_beat_t                     lp_beat,
  output lsm_state_e                     lp_state,
  output logic                           lp_err,

  // Upper layer out
  output logic                           pl_trdy,
  output logic                           pl_valid,
  output logic [LPIF_DATA_BITS-1:0]      pl_data,
  output logic [STREAM_BITS-1:0]         pl_stream,
  output lsm_state_e                     pl_state_sts,
  output logic                           pl_lnk_up
);

  lpif_beat_t lp_q    [PIPE_STAGES];    // Inbound beat stages
  lsm_state_e req_q   [PIPE_STAGES];
  logic       err_q   [PIPE_STAGES];
  lpif_beat_t pl_q    [PIPE_STAGES];    // Outbound beat stages
  lsm_state_e sts_q   [PIPE_STAGES];
  logic       act_q   [PIPE_STAGES];

  logic       accept;

  // Only place where the transfer rule is evaluated
  assign accept = lp_valid & lp_irdy & pl_trdy;

  //////////////////////////////////////////////////////////////////////
  // Upper layer toward core
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < PIPE_STAGES; i++)
      begin
        lp_q[i]  <= '0;
        req_q[i] <= NOP;
        err_q[i] <= 1'b0;
      end
    end
    else
    begin
      lp_q[0]  <= '{valid: accept, stream: lp_stream, data: lp_data};
      req_q[0] <= lp_state_req;
      err_q[0] <= lp_linkerror;
      for (int i = 1; i < PIPE_STAGES; i++)
      begin
        lp_q[i]  <= lp_q[i-1];
        req_q[i] <= req_q[i-1];
        err_q[i] <= err_q[i-1];
      end
    end
  end

  assign lp_beat  = lp_q[PIPE_STAGES-1];
  assign lp_state = req_q[PIPE_STAGES-1];
  assign lp_err   = err_q[PIPE_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // Core toward upper layer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < PIPE_STAGES; i++)
      begin
        pl_q[i]  <= '0;
        sts_q[i] <= NOP;
        act_q[i] <= 1'b0;
      end
    end
    else
    begin
      pl_q[0]  <= rx_beat;
      sts_q[0] <= sts;
      act_q[0] <= link_active;
      for (int i = 1; i < PIPE_STAGES; i++)
      begin
        pl_q[i]  <= pl_q[i-1];
        sts_q[i] <= sts_q[i-1];
        act_q[i] <= act_q[i-1];
      end
    end
  end

  assign pl_valid     = pl_q[PIPE_STAGES-1].valid;
  assign pl_data      = pl_q[PIPE_STAGES-1].data;
  assign pl_stream    = pl_q[PIPE_STAGES-1].stream;
  assign pl_state_sts = sts_q[PIPE_STAGES-1];
  assign pl_trdy      = act_q[PIPE_STAGES-1];   // Ready only with the link up
  assign pl_lnk_up    = act_q[PIPE_STAGES-1];

endmodule

`default_nettype wire

/* hw/lpif_pkg.sv */
`default_nettype none

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int LPIF_DATA_BITS    = 32;                 // One beat of upper-layer data
  localparam int STREAM_BITS       = 8;                  // Stream identifier
  localparam int AIB_LANES         = 2;
  localparam int AIB_BITS_PER_LANE = 40;
  localparam int AIB_WIDTH         = AIB_LANES * AIB_BITS_PER_LANE;

  // Unused low bits of a frame below mark, stream and data
  localparam int AIB_PAD_BITS      = AIB_WIDTH - 1 - STREAM_BITS - LPIF_DATA_BITS;

  // Register stages on each side of the pipeline block
  localparam int PIPE_STAGES       = 1;

  //////////////////////////////////////////////////////////////////////
  // Link states
  //////////////////////////////////////////////////////////////////////

  // Shared by the request from the upper layer and the status back to it
  typedef enum logic [3:0] {
    NOP       = 4'h0,
    ACTIVE    = 4'h1,
    LINKRESET = 4'h9,
    LINKERROR = 4'hA
  } lsm_state_e;

  //////////////////////////////////////////////////////////////////////
  // Beat and frame
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      valid;
    logic [STREAM_BITS-1:0]    stream;
    logic [LPIF_DATA_BITS-1:0] data;
  } lpif_beat_t;

  // Lane i carries bits i*AIB_BITS_PER_LANE upward, so the top lane
  // holds the mark, the stream and the upper part of the data
  typedef struct packed {
    logic                      mark;    // Frame carries a beat
    logic [STREAM_BITS-1:0]    stream;
    logic [LPIF_DATA_BITS-1:0] data;
    logic [AIB_PAD_BITS-1:0]   pad;     // Always zero on transmit
  } aib_frame_t;

endpackage

`default_nettype wire

/* hw/lpif_rx_deframer.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_rx_deframer
  import lpif_pkg::*;
(
  input  wire logic lclk,
  input  wire logic reset,
  input  aib_frame_t rx_frame,
  input  wire logic link_active,
  output lpif_beat_t rx_beat
);

  logic                      rx_valid;
  logic [STREAM_BITS-1:0]    rx_stream;
  logic [LPIF_DATA_BITS-1:0] rx_data;

  //////////////////////////////////////////////////////////////////////
  // Valid flag
  //////////////////////////////////////////////////////////////////////

  // Frames that arrive while the link is down are dropped here
  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
      rx_valid <= 1'b0;
    else
      rx_valid <= rx_frame.mark & link_active;
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    rx_stream <= rx_frame.stream;
    rx_data   <= rx_frame.data;   // Padding bits are ignored
  end

  assign rx_beat = '{valid: rx_valid, stream: rx_stream, data: rx_data};

endmodule

`default_nettype wire

/* hw/lpif_tx_framer.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_tx_framer
  import lpif_pkg::*;
(
  input  wire logic lclk,
  input  wire logic reset,
  input  lpif_beat_t lp_beat,      // Valid only for accepted beats
  output aib_frame_t data_in_f
);

  aib_frame_t frame_nxt;

  // Idle frames carry all zeros, so the far side sees a clean bus
  always_comb
  begin
    frame_nxt = '0;
    if (lp_beat.valid)
    begin
      frame_nxt.mark   = 1'b1;
      frame_nxt.stream = lp_beat.stream;
      frame_nxt.data   = lp_beat.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit frame register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset)
  begin
    if (!reset)
      data_in_f <= '0;           // Idle on the wire
    else
      data_in_f <= frame_nxt;
  end

endmodule

`default_nettype wire

/* project.f */
hw/lpif_pkg.sv
hw/lpif_pipeline.sv
hw/lpif_lsm.sv
hw/lpif_tx_framer.sv
hw/lpif_lpbk.sv
hw/lpif_rx_deframer.sv
hw/lpif_adapter.sv
test/lpif_adapter_checker.sv
test/lpif_adapter_tb.sv

/* test/lpif_adapter_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_adapter_checker
  import lpif_pkg::*;
(
  input  wire logic lclk,
  input  wire logic reset,
  input  wire logic pl_trdy,
  input  wire logic pl_lnk_up,
  input  wire logic pl_valid,
  input  wire logic ns_mac_rdy,
  input  lsm_state_e pl_state_sts
);

  int fail_count = 0;     // Failed assertions so far

  // Ready is offered exactly while the link is up and reported ACTIVE
  trdy_follows_link : assert property (@(posedge lclk)
                                       (pl_trdy == pl_lnk_up) &&
                                       (pl_trdy == (pl_state_sts == ACTIVE)))
    else
    begin
      fail_count++;
      $error("pl_trdy differs from pl_lnk_up or from the ACTIVE status");
    end

  mac_rdy_stays_high : assert property (@(posedge lclk) disable iff (!reset)
                                        ns_mac_rdy |=> ns_mac_rdy)
    else
    begin
      fail_count++;
      $error("ns_mac_rdy fell after it was set");
    end

  sts_is_legal : assert property (@(posedge lclk)
                                  pl_state_sts inside {NOP, ACTIVE, LINKRESET, LINKERROR})
    else
    begin
      fail_count++;
      $error("pl_state_sts holds an undefined state");
    end

  no_valid_in_reset : assert property (@(posedge lclk) !reset |-> !pl_valid)
    else
    begin
      fail_count++;
      $error("pl_valid is high during reset");
    end

endmodule

bind lpif_adapter lpif_adapter_checker chk (
  .lclk         (lclk),
  .reset        (reset),
  .pl_trdy      (pl_trdy),
  .pl_lnk_up    (pl_lnk_up),
  .pl_valid     (pl_valid),
  .ns_mac_rdy   (ns_mac_rdy),
  .pl_state_sts (pl_state_sts)
);

`default_nettype wire

/* test/lpif_adapter_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lpif_adapter_tb
  import lpif_pkg::*;
();

  typedef struct {
    logic                      lpbk;
    lsm_state_e                req;
    logic                      err;
    logic                      fs;
    logic                      valid;
    logic                      irdy;
    logic                      rnd;        // Data drawn from the generator
    logic [LPIF_DATA_BITS-1:0] data;
    logic [STREAM_BITS-1:0]    stream;
    aib_frame_t                dout;
  } step_t;

  logic                      lclk;
  logic                      reset;
  logic                      lp_irdy;
  logic                      lp_valid;
  logic [LPIF_DATA_BITS-1:0] lp_data;
  logic [STREAM_BITS-1:0]    lp_stream;
  lsm_state_e                lp_state_req;
  logic                      lp_linkerror;
  logic                      fs_mac_rdy;
  logic                      lpbk_en;
  aib_frame_t                dout;
  logic                      pl_trdy;
  logic                      pl_valid;
  logic [LPIF_DATA_BITS-1:0] pl_data;
  logic [STREAM_BITS-1:0]    pl_stream;
  lsm_state_e                pl_state_sts;
  logic                      pl_lnk_up;
  logic                      ns_mac_rdy;
  aib_frame_t                data_in_f;

  step_t      steps[$];                // Stimulus table
  lpif_beat_t exp_pl[$];               // Expected pl beats, two edges ahead
  step_t      idle_step;
  step_t      cur;
  step_t      smp;                     // Inputs seen at the current edge
  logic [31:0] rng;
  logic       table_ready = 1'b0;

  // Reference model state, each as seen after the current edge
  lsm_state_e st;
  lsm_state_e st_new;
  lsm_state_e sts_q;
  lsm_state_e req_q;
  logic       err_q;
  logic       trdy_q;
  logic       acc;
  lpif_beat_t beat_q;
  aib_frame_t frame_q;
  aib_frame_t rxf;
  lpif_beat_t pl_exp;

  lpif_adapter dut (.*);

  initial
  begin
    lclk = 1'b0;
    forever #10 lclk = ~lclk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Mark on top, then stream, then data, padding left at zero
  function automatic aib_frame_t make_frame(input logic mark, input logic [7:0] stream,
                                            input logic [31:0] data);
    aib_frame_t f;
    f = '0;
    if (mark)
    begin
      f.mark   = 1'b1;
      f.stream = stream;
      f.data   = data;
    end
    return f;
  endfunction

  function automatic lsm_state_e next_state(input lsm_state_e cur_st, input lsm_state_e req,
                                            input logic err, input logic fs);
    lsm_state_e n;
    n = cur_st;
    if (err)
      n = LINKERROR;                     // Error overrides any request
    else if ((cur_st == NOP || cur_st == LINKRESET) && req == ACTIVE && fs)
      n = ACTIVE;
    else if ((cur_st == ACTIVE || cur_st == LINKERROR) && req == LINKRESET)
      n = LINKRESET;
    return n;
  endfunction

  task automatic add_step(input logic lpbk, input lsm_state_e req, input logic err,
                          input logic fs, input logic valid, input logic irdy, input logic rnd,
                          input logic [31:0] data, input logic [7:0] stream,
                          input aib_frame_t frame);
    steps.push_back('{lpbk, req, err, fs, valid, irdy, rnd, data, stream, frame});
  endtask

  task automatic drive_inputs(input step_t s);
    lpbk_en      <= s.lpbk;
    lp_state_req <= s.req;
    lp_linkerror <= s.err;
    fs_mac_rdy   <= s.fs;
    lp_valid     <= s.valid;
    lp_irdy      <= s.irdy;
    lp_data      <= s.data;
    lp_stream    <= s.stream;
    dout         <= s.dout;
  endtask

  task automatic check_value(input string name, input logic [AIB_WIDTH-1:0] actual,
                             input logic [AIB_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_outputs(input logic trdy, input lsm_state_e sts, input aib_frame_t frame,
                               input lpif_beat_t beat, input logic mac_rdy);
    check_value("pl_trdy", pl_trdy, trdy);
    check_value("pl_lnk_up", pl_lnk_up, trdy);
    check_value("pl_state_sts", pl_state_sts, sts);
    check_value("ns_mac_rdy", ns_mac_rdy, mac_rdy);
    check_value("data_in_f", data_in_f, frame);
    check_value("pl_valid", pl_valid, beat.valid);
    if (beat.valid)
    begin
      check_value("pl_data", pl_data, beat.data);
      check_value("pl_stream", pl_stream, beat.stream);
    end
  endtask

  task automatic build_table();
    aib_frame_t junk;
    junk = make_frame(1'b1, 8'hee, 32'hffff_ffff);   // Ignored while looping back
    // Bring-up, beats offered before the link is up
    repeat (2) add_step(0, NOP, 0, 0, 0, 0, 0, '0, '0, '0);
    repeat (3) add_step(0, ACTIVE, 0, 0, 1, 1, 0, 32'h0bad_f00d, 8'h01, '0);
    repeat (3) add_step(0, ACTIVE, 0, 1, 1, 1, 0, 32'h0bad_f00d, 8'h02, '0);
    // Framing with gaps
    add_step(0, ACTIVE, 0, 1, 1, 1, 0, 32'h1234_5678, 8'h11, '0);
    add_step(0, ACTIVE, 0, 1, 1, 0, 0, 32'hdead_beef, 8'h22, '0);
    add_step(0, ACTIVE, 0, 1, 1, 1, 0, 32'hcafe_0001, 8'h33, '0);
    add_step(0, ACTIVE, 0, 1, 0, 1, 0, 32'hcafe_0002, 8'h44, '0);
    for (int i = 0; i < 10; i++)
      add_step(1, ACTIVE, 0, 1, 1, (i != 3) && (i != 7), 1, '0, 8'(i + 'h50), junk);
    repeat (4) add_step(1, ACTIVE, 0, 1, 0, 0, 0, '0, '0, junk);
    // Far-side frames, one of them idle
    for (int i = 0; i < 4; i++)
      add_step(0, ACTIVE, 0, 1, 0, 0, 0, '0, '0,
               make_frame(i != 2, 8'(i + 'h70), 32'(i + 'ha5a5_0000)));
    // Link error and recovery
    repeat (3) add_step(0, ACTIVE, 1, 1, 1, 1, 0, 32'h5555_aaaa, 8'h80,
                        make_frame(1'b1, 8'h81, 32'h1111_2222));
    repeat (3) add_step(0, LINKRESET, 0, 1, 0, 0, 0, '0, '0,
                        make_frame(1'b1, 8'h82, 32'h3333_4444));
    repeat (3) add_step(0, ACTIVE, 0, 1, 0, 0, 0, '0, '0, '0);
    repeat (6) add_step(1, ACTIVE, 0, 1, 1, 1, 1, '0, 8'h90, junk);
    repeat (4) add_step(1, ACTIVE, 0, 1, 0, 0, 0, '0, '0, junk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rng       = 32'd55990;
    idle_step = '{1'b0, NOP, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0};
    drive_inputs(idle_step);
    reset <= 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (10)
    begin
      @(negedge lclk);
      check_outputs(1'b0, NOP, '0, '0, 1'b0);
    end
    @(posedge lclk);
    reset <= 1'b1;
    smp     = idle_step;
    st      = NOP;
    req_q   = NOP;
    err_q   = 1'b0;
    trdy_q  = 1'b0;
    beat_q  = '0;
    frame_q = '0;
    exp_pl.push_back('0);
    exp_pl.push_back('0);
    for (int t = 0; t < steps.size() + 6; t++)
    begin
      @(posedge lclk);
      acc    = smp.valid & smp.irdy & trdy_q;            // Transfer at this edge
      rxf    = smp.lpbk ? frame_q : smp.dout;             // Frame now in loopback stage
      st_new = next_state(st, req_q, err_q, smp.fs);
      exp_pl.push_back('{valid: rxf.mark & (st_new == ACTIVE), stream: rxf.stream,
                         data: rxf.data});
      frame_q = make_frame(beat_q.valid, beat_q.stream, beat_q.data);
      beat_q  = '{valid: acc, stream: smp.stream, data: smp.data};
      trdy_q  = (st == ACTIVE);
      sts_q   = st;
      st      = st_new;
      req_q   = smp.req;
      err_q   = smp.err;
      if (t < steps.size())
        cur = steps[t];
      else
        cur = idle_step;
      if (cur.rnd)
      begin
        rng      = xorshift32(rng);
        cur.data = rng;
      end
      drive_inputs(cur);
      smp = cur;
      @(negedge lclk);
      pl_exp = exp_pl.pop_front();
      check_outputs(trdy_q, sts_q, frame_q, pl_exp, 1'b1);
    end
    if (dut.chk.fail_count == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("Error: %0d assertion failures in the checker", dut.chk.fail_count);
      $display("TEST FAILED");
      $fatal(1, "Assertion failures");
    end
  end

  // Stop as soon as the bound checker flags a violation
  initial
  begin
    wait (dut.chk.fail_count != 0);
    $display("Error: an assertion in the checker failed");
    $display("TEST FAILED");
    $fatal(1, "Assertion failure");
  end

  // Watchdog sized from the table
  initial
  begin
    wait (table_ready);
    #((steps.size() + 50) * 20);
    $display("Error: timeout, the run did not finish within %0d cycles", steps.size() + 50);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire
